/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f vid_frame_ctrl.f \
    && ./obj_dir/Vtb_top | tee /dev/stderr \
        | grep -x "Simulation completed successfully" > /dev/null \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* src/buf_req_if.sv */
interface buf_req_if;
    import vid_pkg::*;

    logic              acq;
    logic              rel;
    logic              gnt;
    logic [ADDR_W-1:0] base;
    logic [IDX_W-1:0]  idx;

    modport channel (
        output acq,
        output rel,
        input  gnt,
        input  base,
        input  idx
    );

    modport tbl (
        input  acq,
        input  rel,
        output gnt,
        output base,
        output idx
    );

endinterface

/* src/frame_buf_table.sv */
module frame_buf_table #(
    parameter int BURST_WORDS  = 32,
    parameter int FRAME_BURSTS = 8,
    parameter int INIT_DELAY   = 152
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   init_done_i,
    buf_req_if.tbl up_if,
    buf_req_if.tbl dn_if
);
    import vid_pkg::*;

    localparam int DLY_W = $clog2(INIT_DELAY + 1);

    logic [DLY_W-1:0]                  dly_q;
    logic                              ready;
    logic [NUM_FRAMES-1:0][ST_W-1:0]   st_q;
    logic                              last_dn_q;
    logic                              up_req;
    logic                              dn_req;
    logic                              up_win;
    logic                              dn_win;
    logic [IDX_W-1:0]                  up_pick;
    logic [IDX_W-1:0]                  dn_pick;
    logic [IDX_W-1:0]                  up_held_q;
    logic [IDX_W-1:0]                  dn_held_q;

    // later loops overwrite earlier ones, so first class wins,
    // and the ascending scan leaves the highest index
    function automatic logic [IDX_W-1:0] pick_buf(
        input logic [NUM_FRAMES-1:0][ST_W-1:0] st,
        input logic [ST_W-1:0]                 first,
        input logic [ST_W-1:0]                 second,
        input logic [ST_W-1:0]                 third
    );
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (st[i] == third)
                idx = IDX_W'(i);
        end
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (st[i] == second)
                idx = IDX_W'(i);
        end
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (st[i] == first)
                idx = IDX_W'(i);
        end
        return idx;
    endfunction

    // memory startup delay
    assign ready = (dly_q == DLY_W'(INIT_DELAY));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dly_q <= '0;
        else if (init_done_i && !ready)
            dly_q <= dly_q + 1'b1;
    end

    assign up_pick = pick_buf(st_q, BUF_DISPLAYED, BUF_AVAILABLE, BUF_UPDATED);
    assign dn_pick = pick_buf(st_q, BUF_UPDATED, BUF_AVAILABLE, BUF_DISPLAYED);

    // round-robin between the two channels
    assign up_req = ready & (up_if.acq | up_if.rel);
    assign dn_req = ready & (dn_if.acq | dn_if.rel);
    assign up_win = up_req & (~dn_req | last_dn_q);
    assign dn_win = dn_req & ~up_win;

    assign up_if.gnt  = up_win;
    assign up_if.idx  = up_pick;
    assign up_if.base = buf_base(up_pick, FRAME_BURSTS, BURST_WORDS);
    assign dn_if.gnt  = dn_win;
    assign dn_if.idx  = dn_pick;
    assign dn_if.base = buf_base(dn_pick, FRAME_BURSTS, BURST_WORDS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_FRAMES; i++)
                st_q[i] <= BUF_AVAILABLE;
            // upload goes first on a tie
            last_dn_q <= 1'b1;
        end else begin
            if (up_win) begin
                last_dn_q <= 1'b0;
                if (up_if.acq)
                    st_q[up_pick] <= BUF_WRITE_BUSY;
                else
                    st_q[up_held_q] <= BUF_UPDATED;
            end
            if (dn_win) begin
                last_dn_q <= 1'b1;
                if (dn_if.acq)
                    st_q[dn_pick] <= BUF_READ_BUSY;
                else
                    st_q[dn_held_q] <= BUF_DISPLAYED;
            end
        end
    end

    // buffer held by each channel until release
    always_ff @(posedge clk) begin
        if (up_win && up_if.acq)
            up_held_q <= up_if.idx;
        if (dn_win && dn_if.acq)
            dn_held_q <= dn_if.idx;
    end

    a_up_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        up_win && up_if.acq |->
            st_q[up_if.idx] != BUF_WRITE_BUSY && st_q[up_if.idx] != BUF_READ_BUSY
    ) else $error("upload channel got a busy buffer");

    a_dn_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        dn_win && dn_if.acq |->
            st_q[dn_if.idx] != BUF_WRITE_BUSY && st_q[dn_if.idx] != BUF_READ_BUSY
    ) else $error("download channel got a busy buffer");

endmodule

/* src/frame_channel.sv */
module frame_channel #(
    parameter bit IS_WRITE     = 1'b1,
    parameter int BURST_WORDS  = 32,
    parameter int FRAME_BURSTS = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en_i,
    input  logic                        mem_gnt_i,
    output logic                        mem_req_o,
    output logic [vid_pkg::ADDR_W-1:0]  mem_addr_o,
    buf_req_if.channel                  buf_if
);
    import vid_pkg::*;

    localparam int CNT_W = $clog2(FRAME_BURSTS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACQ,
        S_XFER,
        S_REL
    } state_e;

    state_e            state_q;
    logic              req_q;
    logic [CNT_W-1:0]  cnt_q;
    logic [ADDR_W-1:0] base_q;
    logic              last_burst;

    assign last_burst = (cnt_q == CNT_W'(FRAME_BURSTS - 1));

    assign buf_if.acq = (state_q == S_ACQ);
    assign buf_if.rel = (state_q == S_REL);

    assign mem_req_o  = req_q;
    assign mem_addr_o = base_q + ADDR_W'(BURST_WORDS * int'(cnt_q));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            req_q   <= 1'b0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (en_i)
                        state_q <= S_ACQ;
                end
                S_ACQ: begin
                    if (buf_if.gnt) begin
                        state_q <= S_XFER;
                        cnt_q   <= '0;
                    end
                end
                S_XFER: begin
                    // first cycle lets the table settle the buffer state
                    if (!req_q) begin
                        req_q <= 1'b1;
                    end else if (mem_gnt_i) begin
                        if (last_burst) begin
                            req_q   <= 1'b0;
                            state_q <= S_REL;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                S_REL: begin
                    if (buf_if.gnt)
                        state_q <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // base of the buffer granted for this frame
    always_ff @(posedge clk) begin
        if (state_q == S_ACQ && buf_if.gnt)
            base_q <= buf_if.base;
    end

    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_o && !mem_gnt_i |=> mem_req_o
    ) else $error("%s channel dropped mem_req without grant", IS_WRITE ? "write" : "read");

endmodule

/* src/mem_cmd_arbiter.sv */
module mem_cmd_arbiter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_req_i,
    input  logic                        rd_req_i,
    input  logic [vid_pkg::ADDR_W-1:0]  wr_addr_i,
    input  logic [vid_pkg::ADDR_W-1:0]  rd_addr_i,
    output logic                        wr_gnt_o,
    output logic                        rd_gnt_o,
    output logic                        cmd_en_o,
    output logic                        cmd_o,
    output logic [vid_pkg::ADDR_W-1:0]  addr_o
);

    // set when the read side won last
    logic last_rd_q;

    assign wr_gnt_o = wr_req_i & (~rd_req_i | last_rd_q);
    assign rd_gnt_o = rd_req_i & ~wr_gnt_o;

    assign cmd_en_o = wr_gnt_o | rd_gnt_o;
    assign cmd_o    = wr_gnt_o;

    always_comb begin
        if (wr_gnt_o)
            addr_o = wr_addr_i;
        else if (rd_gnt_o)
            addr_o = rd_addr_i;
        else
            addr_o = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            last_rd_q <= 1'b1;
        else if (wr_gnt_o)
            last_rd_q <= 1'b0;
        else if (rd_gnt_o)
            last_rd_q <= 1'b1;
    end

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({wr_gnt_o, rd_gnt_o})
    ) else $error("write and read granted together");

endmodule

/* src/vid_frame_ctrl.sv */
module vid_frame_ctrl #(
    parameter int BURST_WORDS  = 32,
    parameter int FRAME_BURSTS = 8,
    parameter int INIT_DELAY   = 152
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        init_done_i,
    input  logic                        upload_en_i,
    input  logic                        download_en_i,
    output logic                        cmd_en_o,
    output logic                        cmd_o,
    output logic [vid_pkg::ADDR_W-1:0]  addr_o
);
    import vid_pkg::*;

    logic              wr_req;
    logic              wr_gnt;
    logic [ADDR_W-1:0] wr_addr;
    logic              rd_req;
    logic              rd_gnt;
    logic [ADDR_W-1:0] rd_addr;

    buf_req_if up_if ();
    buf_req_if dn_if ();

    frame_buf_table #(
        .BURST_WORDS  (BURST_WORDS),
        .FRAME_BURSTS (FRAME_BURSTS),
        .INIT_DELAY   (INIT_DELAY)
    ) u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .init_done_i (init_done_i),
        .up_if       (up_if),
        .dn_if       (dn_if)
    );

    frame_channel #(
        .IS_WRITE     (1'b1),
        .BURST_WORDS  (BURST_WORDS),
        .FRAME_BURSTS (FRAME_BURSTS)
    ) u_upload (
        .clk        (clk),
        .rst_n      (rst_n),
        .en_i       (upload_en_i),
        .mem_gnt_i  (wr_gnt),
        .mem_req_o  (wr_req),
        .mem_addr_o (wr_addr),
        .buf_if     (up_if)
    );

    frame_channel #(
        .IS_WRITE     (1'b0),
        .BURST_WORDS  (BURST_WORDS),
        .FRAME_BURSTS (FRAME_BURSTS)
    ) u_download (
        .clk        (clk),
        .rst_n      (rst_n),
        .en_i       (download_en_i),
        .mem_gnt_i  (rd_gnt),
        .mem_req_o  (rd_req),
        .mem_addr_o (rd_addr),
        .buf_if     (dn_if)
    );

    mem_cmd_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req_i  (wr_req),
        .rd_req_i  (rd_req),
        .wr_addr_i (wr_addr),
        .rd_addr_i (rd_addr),
        .wr_gnt_o  (wr_gnt),
        .rd_gnt_o  (rd_gnt),
        .cmd_en_o  (cmd_en_o),
        .cmd_o     (cmd_o),
        .addr_o    (addr_o)
    );

endmodule

/* src/vid_pkg.sv */
package vid_pkg;

    localparam int ADDR_W = 21;
    localparam int NUM_FRAMES = 3;
    localparam int IDX_W = 2;
    localparam int ST_W = 3;

    // buffer states
    localparam logic [ST_W-1:0] BUF_AVAILABLE  = 3'd0;
    localparam logic [ST_W-1:0] BUF_WRITE_BUSY = 3'd1;
    localparam logic [ST_W-1:0] BUF_READ_BUSY  = 3'd2;
    localparam logic [ST_W-1:0] BUF_DISPLAYED  = 3'd3;
    localparam logic [ST_W-1:0] BUF_UPDATED    = 3'd4;

    // one spare burst between frames
    function automatic logic [ADDR_W-1:0] buf_base(
        input logic [IDX_W-1:0] idx,
        input int               frame_bursts,
        input int               burst_words
    );
        int stride;
        stride = frame_bursts * burst_words + burst_words;
        return ADDR_W'(int'(idx) * stride);
    endfunction

endpackage

/* verif/tb_checker.sv */
module tb_checker #(
    parameter int BURST_WORDS  = 32,
    parameter int FRAME_BURSTS = 8,
    parameter int INIT_DELAY   = 152
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       init_done_i,
    input  logic                       cmd_en_i,
    input  logic                       cmd_i,
    input  logic [vid_pkg::ADDR_W-1:0] addr_i,
    input  logic                       row_start_i,
    input  logic [8*12-1:0]            name_i,
    input  logic                       up_exp_i,
    input  logic                       dn_exp_i,
    input  logic [vid_pkg::ADDR_W-1:0] wr_base_i,
    input  logic [vid_pkg::ADDR_W-1:0] rd_base_i,
    input  int                         need_i,
    output logic                       wr_seen_o,
    output logic                       rd_seen_o,
    output logic                       row_done_o,
    output int                         value_errs_o,
    output int                         proto_errs_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import vid_pkg::*;

    // index 1 is the write channel, 0 the read channel
    int                ready_cnt;
    int                cnt [2];
    logic [ADDR_W-1:0] first [2];
    logic              last_cmd = 1'b0;
    logic              in_rst_q = 1'b0;

    function automatic logic [ADDR_W-1:0] burst_addr(input logic [ADDR_W-1:0] base, input int n);
        return base + ADDR_W'(n * BURST_WORDS);
    endfunction

    assign wr_seen_o  = cnt[1] > 0;
    assign rd_seen_o  = cnt[0] > 0;
    assign row_done_o = (!up_exp_i || cnt[1] >= need_i) && (!dn_exp_i || cnt[0] >= need_i);

    always @(posedge clk) begin
        in_rst_q <= !rst_n;
        if (!rst_n) begin
            ready_cnt <= 0;
            if (in_rst_q && (cmd_en_i || cmd_i || addr_i != '0)) begin
                $display("%0s: command port not idle during reset", name_i);
                proto_errs_o++;
            end
        end else begin
            if (init_done_i && ready_cnt < INIT_DELAY)
                ready_cnt <= ready_cnt + 1;
            if (cmd_en_i && ready_cnt < INIT_DELAY) begin
                $display("%0s: command issued before the memory startup delay ended", name_i);
                proto_errs_o++;
            end
            if (row_start_i) begin
                cnt[0] <= 0;
                cnt[1] <= 0;
            end else begin
                // both channels mid frame, so both hold a request
                if (up_exp_i && dn_exp_i && cnt[1] > 0 && cnt[1] < need_i
                        && cnt[0] > 0 && cnt[0] < need_i
                        && (!cmd_en_i || cmd_i == last_cmd)) begin
                    $display("%0s: command port did not alternate between channels", name_i);
                    proto_errs_o++;
                end
                if (cmd_en_i) begin
                    last_cmd <= cmd_i;
                    if (!(cmd_i ? up_exp_i : dn_exp_i) || cnt[cmd_i] >= FRAME_BURSTS) begin
                        $display("%0s: unexpected %0s command at %0h", name_i,
                                 cmd_i ? "write" : "read", addr_i);
                        proto_errs_o++;
                    end else begin
                        if (addr_i != burst_addr(cmd_i ? wr_base_i : rd_base_i, cnt[cmd_i])) begin
                            $display("ERR %0s: %0s burst %0d expected %0h actual %0h", name_i,
                                     cmd_i ? "write" : "read", cnt[cmd_i],
                                     burst_addr(cmd_i ? wr_base_i : rd_base_i, cnt[cmd_i]),
                                     addr_i);
                            value_errs_o++;
                        end
                        if (cnt[cmd_i] == 0 && cnt[!cmd_i] > 0 && addr_i == first[!cmd_i]) begin
                            $display("%0s: write and read frames share base %0h", name_i, addr_i);
                            proto_errs_o++;
                        end
                        if (cnt[cmd_i] == 0)
                            first[cmd_i] <= addr_i;
                        cnt[cmd_i] <= cnt[cmd_i] + 1;
                    end
                end
            end
        end
    end

endmodule

/* verif/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* verif/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import vid_pkg::*;

    localparam int BURST_WORDS     = 32;
    localparam int FRAME_BURSTS    = 8;
    localparam int INIT_DELAY      = 152;
    localparam int STRIDE          = FRAME_BURSTS * BURST_WORDS + BURST_WORDS;
    localparam int NUM_ROWS        = 7;
    localparam int RESET_HOLD      = 3;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (INIT_DELAY + 4 * FRAME_BURSTS + 20);

    // one frame per enabled channel, cut resets after that many bursts
    typedef struct packed {
        logic [8*12-1:0]   name;
        logic              up;
        logic              dn;
        logic [ADDR_W-1:0] wr_base;
        logic [ADDR_W-1:0] rd_base;
        logic              boot;
        logic [7:0]        cut;
    } row_t;

    logic              clk;
    logic              gen_rst_n;
    logic              mid_rst_n;
    logic              rst_n;
    logic              init_done;
    logic              upload_en;
    logic              download_en;
    logic              cmd_en;
    logic              cmd;
    logic [ADDR_W-1:0] addr;
    logic              row_start;
    row_t              cur;
    int                need;
    logic              wr_seen;
    logic              rd_seen;
    logic              row_done;
    int                value_errs;
    int                proto_errs;
    int                seed;
    row_t              rows [NUM_ROWS];

    tb_clk_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (5)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (gen_rst_n)
    );

    assign rst_n = gen_rst_n & mid_rst_n;
    assign need  = (cur.cut != 8'd0) ? int'(cur.cut) : FRAME_BURSTS;

    vid_frame_ctrl #(
        .BURST_WORDS  (BURST_WORDS),
        .FRAME_BURSTS (FRAME_BURSTS),
        .INIT_DELAY   (INIT_DELAY)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_done_i   (init_done),
        .upload_en_i   (upload_en),
        .download_en_i (download_en),
        .cmd_en_o      (cmd_en),
        .cmd_o         (cmd),
        .addr_o        (addr)
    );

    tb_checker #(
        .BURST_WORDS  (BURST_WORDS),
        .FRAME_BURSTS (FRAME_BURSTS),
        .INIT_DELAY   (INIT_DELAY)
    ) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_done_i  (init_done),
        .cmd_en_i     (cmd_en),
        .cmd_i        (cmd),
        .addr_i       (addr),
        .row_start_i  (row_start),
        .name_i       (cur.name),
        .up_exp_i     (cur.up),
        .dn_exp_i     (cur.dn),
        .wr_base_i    (cur.wr_base),
        .rd_base_i    (cur.rd_base),
        .need_i       (need),
        .wr_seen_o    (wr_seen),
        .rd_seen_o    (rd_seen),
        .row_done_o   (row_done),
        .value_errs_o (value_errs),
        .proto_errs_o (proto_errs)
    );

    // memory ready with random gaps until enough high cycles
    task automatic drive_init_done();
        int high;
        int r;
        high = 0;
        while (high < INIT_DELAY) begin
            @(posedge clk);
            r = $random(seed);
            if (r[1:0] != 2'b00) begin
                init_done <= 1'b1;
                high++;
            end else begin
                init_done <= 1'b0;
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        cur         <= r;
        row_start   <= 1'b1;
        upload_en   <= r.up;
        download_en <= r.dn;
        @(posedge clk);
        row_start <= 1'b0;
        if (r.boot)
            drive_init_done();
        // enables drop once the channel has started its frame
        do begin
            @(posedge clk);
            if (wr_seen)
                upload_en <= 1'b0;
            if (rd_seen)
                download_en <= 1'b0;
        end while (!row_done);
        if (r.cut != 8'd0) begin
            mid_rst_n   <= 1'b0;
            init_done   <= 1'b0;
            upload_en   <= 1'b0;
            download_en <= 1'b0;
            repeat (RESET_HOLD) @(posedge clk);
            mid_rst_n <= 1'b1;
        end
    endtask

    initial begin
        seed        = 32'h10f8;
        mid_rst_n   = 1'b1;
        init_done   = 1'b0;
        upload_en   = 1'b0;
        download_en = 1'b0;
        row_start   = 1'b0;
        cur         = '0;
        //           name            up    dn    write base          read base          boot  cut
        rows[0] = '{"up_first",     1'b1, 1'b0, ADDR_W'(2 * STRIDE), ADDR_W'(0),        1'b1, 8'd0};
        rows[1] = '{"dn_updated",   1'b0, 1'b1, ADDR_W'(0),          ADDR_W'(2*STRIDE), 1'b0, 8'd0};
        rows[2] = '{"up_displayed", 1'b1, 1'b0, ADDR_W'(2 * STRIDE), ADDR_W'(0),        1'b0, 8'd0};
        rows[3] = '{"both_first",   1'b1, 1'b1, ADDR_W'(1 * STRIDE), ADDR_W'(2*STRIDE), 1'b0, 8'd0};
        rows[4] = '{"both_second",  1'b1, 1'b1, ADDR_W'(2 * STRIDE), ADDR_W'(STRIDE),   1'b0, 8'd0};
        rows[5] = '{"up_reset",     1'b1, 1'b0, ADDR_W'(1 * STRIDE), ADDR_W'(0),        1'b0, 8'd3};
        rows[6] = '{"up_after_rst", 1'b1, 1'b0, ADDR_W'(2 * STRIDE), ADDR_W'(0),        1'b1, 8'd0};
        wait (rst_n === 1'b1);
        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(rows[i]);
        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a frame never completed", WATCHDOG_CYCLES);
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* vid_frame_ctrl.f */
src/vid_pkg.sv
src/buf_req_if.sv
src/frame_buf_table.sv
src/frame_channel.sv
src/mem_cmd_arbiter.sv
src/vid_frame_ctrl.sv
verif/tb_clk_gen.sv
verif/tb_checker.sv
verif/tb_top.sv
